// ==== build.f ====
verilog/zx_bus_pkg.sv
verilog/zx_mem_pkg.sv
verilog/resetter.sv
verilog/zports.sv
verilog/zmem.sv
verilog/arbiter.sv
verilog/zx_top.sv
sim/tb_zx_top.sv

// ==== sim/tb_zx_top.sv ====
module tb_zx_top
	import zx_bus_pkg::*, zx_mem_pkg::*;
();

	timeunit 1ns;
	timeprecision 1ns;

	localparam int RST_CNT_SIZE = 4;
	localparam int N_FE       = 8;
	localparam int N_PAGE     = 6;
	localparam int N_RW       = 4;
	localparam int N_CONT     = 24;
	localparam int N_TRANS    = 2 * N_FE + N_PAGE * (1 + 2 * N_RW) + N_CONT + 30;
	localparam int MAX_CYCLES = 40 * N_TRANS;

	logic       fclk;
	logic       rst;
	zaddr_t     za;
	zdata_t     zd_in;
	logic       mreq_n;
	logic       iorq_n;
	logic       rd_n;
	logic       wr_n;
	logic       m1_n;
	logic [4:0] keys;
	zdata_t     zd_out;
	logic       zd_oe;
	logic       wait_n;
	logic       res;
	logic [2:0] border;
	logic       beep;
	logic       video_req;
	dram_addr_t video_addr;
	logic       video_strobe;
	dram_data_t video_data;
	logic       dram_req;
	dram_cmd_t  dram_cmd;
	logic       dram_rrdy;
	dram_data_t dram_rddata;

	// reference copy of the port registers
	zdata_t      m7ffd;
	zdata_t      meff7;
	logic [2:0]  m_border;
	logic        m_beep;
	dram_data_t  mem [dram_addr_t];
	zdata_t      shadow [logic [21:0]];
	dram_addr_t  vq [$];
	dram_addr_t  va;
	logic        rrdy_d1;
	dram_data_t  rd_d1;
	logic        video_on;
	int unsigned seed;
	int unsigned vseed;
	int          errors;
	int          checks;
	int          cycles;
	int          nvid;

	zx_top #(.RST_CNT_SIZE(RST_CNT_SIZE), .SLOT_LEN(4)) dut (.*);

	initial
	begin
		fclk = 1'b0;
		forever #10 fclk = ~fclk;
	end

	function automatic int unsigned lcg(input int unsigned s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	function automatic int unsigned next_rand();
		seed = lcg(seed);
		return seed >> 8;
	endfunction

	// unwritten words read back a pattern of the full address
	function automatic dram_data_t fill(input dram_addr_t a);
		return a[15:0] ^ {a[20:16], a[20:10]};
	endfunction

	function automatic dram_data_t model_word(input dram_addr_t a);
		return mem.exists(a) ? mem[a] : fill(a);
	endfunction

	function automatic page_t exp_page(input zaddr_t a);
		case (a[15:14])
		2'd0:    return meff7[3] ? 8'd0 : 8'd252 + m7ffd[4];
		2'd1:    return 8'd5;
		2'd2:    return 8'd2;
		default: return {2'b00, m7ffd[7:5], m7ffd[2:0]};
		endcase
	endfunction

	function automatic zdata_t ref_byte(input zaddr_t a);
		dram_data_t w;
		if (shadow.exists({exp_page(a), a[13:0]}))
			return shadow[{exp_page(a), a[13:0]}];
		w = fill({exp_page(a), a[13:1]});
		return a[0] ? w[15:8] : w[7:0];
	endfunction

	function automatic zaddr_t ram_addr();
		zaddr_t a;
		a = zaddr_t'(next_rand());
		a[15:14] = 2'(1 + next_rand() % 3);
		return a;
	endfunction

	task automatic check(input logic [31:0] got, input logic [31:0] exp, input string msg);
		checks++;
		if (got !== exp)
		begin
			errors++;
			$display("Mismatch at %0t ns: %s, got %0h expected %0h", $time, msg, got, exp);
		end
	endtask

	task automatic io_write(input zaddr_t a, input zdata_t d);
		@(posedge fclk);
		za     <= a;
		zd_in  <= d;
		iorq_n <= 1'b0;
		wr_n   <= 1'b0;
		@(posedge fclk);
		@(posedge fclk);
		iorq_n <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic port_write(input zaddr_t a, input zdata_t d);
		if (!a[0])
		begin
			m_border = d[2:0];
			m_beep   = d[4];
		end
		if (a == 16'h7FFD && !m7ffd[5])
			m7ffd = d;
		if (a == 16'hEFF7)
			meff7 = d;
		io_write(a, d);
	endtask

	task automatic fe_read(input logic [4:0] k);
		@(posedge fclk);
		keys   <= k;
		za     <= {8'(next_rand()), 8'hFE};
		iorq_n <= 1'b0;
		rd_n   <= 1'b0;
		@(posedge fclk);
		@(negedge fclk);
		check(zd_oe, 1'b1, "fe read oe");
		check(zd_out, {3'b111, k}, "fe read data");
		@(posedge fclk);
		iorq_n <= 1'b1;
		rd_n   <= 1'b1;
		@(negedge fclk);
		check(zd_oe, 1'b0, "oe after fe read");
	endtask

	task automatic mem_access(input zaddr_t a, input logic wr, input zdata_t d,
		input logic exp_req);
		dram_addr_t ea;
		zdata_t     exp_b;
		int         reqs;
		ea    = {exp_page(a), a[13:1]};
		exp_b = ref_byte(a);
		reqs  = 0;
		@(posedge fclk);
		za     <= a;
		zd_in  <= d;
		mreq_n <= 1'b0;
		if (wr)
			wr_n <= 1'b0;
		else
			rd_n <= 1'b0;
		@(posedge fclk);
		if (exp_req)
		begin
			do
			begin
				@(negedge fclk);
				// video fetches always read both bytes
				if (dram_req === 1'b1 && dram_cmd.bsel != 2'b11)
				begin
					reqs++;
					check(dram_cmd.addr, ea, "dram addr");
					check(dram_cmd.rnw, !wr, "dram rnw");
					check(dram_cmd.bsel, a[0] ? 2'b10 : 2'b01, "dram bsel");
					if (wr)
						check(dram_cmd.wrdata, {d, d}, "dram write data");
				end
			end while (wait_n !== 1'b1);
			check(reqs, 1, "cpu dram requests");
			if (!wr)
			begin
				check(zd_oe, 1'b1, "read oe");
				check(zd_out, exp_b, "read byte");
			end
			else
				shadow[{exp_page(a), a[13:0]}] = d;
		end
		else
		begin
			repeat (4)
			begin
				@(negedge fclk);
				check(wait_n, 1'b1, "wait_n on rom write");
				if (dram_req === 1'b1 && dram_cmd.bsel != 2'b11)
					reqs++;
			end
			check(reqs, 0, "dram requests on rom write");
		end
		@(posedge fclk);
		mreq_n <= 1'b1;
		rd_n   <= 1'b1;
		wr_n   <= 1'b1;
	endtask

	task automatic end_test(input string name, input int err0);
		$display("%s: %0d errors", name, errors - err0);
	endtask

	// DRAM behind the top level with a fixed 2 cycle return
	always @(posedge fclk)
	begin
		dram_data_t w;
		rrdy_d1     <= (dram_req === 1'b1);
		dram_rrdy   <= rrdy_d1;
		dram_rddata <= rd_d1;
		if (dram_req === 1'b1)
		begin
			w = model_word(dram_cmd.addr);
			rd_d1 <= w;
			if (!dram_cmd.rnw)
			begin
				if (dram_cmd.bsel[0])
					w[7:0] = dram_cmd.wrdata[7:0];
				if (dram_cmd.bsel[1])
					w[15:8] = dram_cmd.wrdata[15:8];
				mem[dram_cmd.addr] = w;
			end
		end
	end

	// one video fetch outstanding at a time from pages the CPU never touches
	always @(posedge fclk)
	begin
		video_req <= 1'b0;
		if (video_on && vq.size() == 0)
		begin
			vseed = lcg(vseed);
			if (vseed[20:19] == 2'b00)
			begin
				va = {3'b100, vseed[29:12]};
				video_req  <= 1'b1;
				video_addr <= va;
				vq.push_back(va);
			end
		end
	end

	always @(negedge fclk)
	begin
		if (video_strobe === 1'b1)
		begin
			if (vq.size() == 0)
			begin
				errors++;
				$display("video strobe at %0t ns with no video request pending", $time);
			end
			else
			begin
				check(video_data, model_word(vq[0]), "video data");
				void'(vq.pop_front());
				nvid++;
			end
		end
	end

	always @(posedge fclk)
	begin
		cycles++;
		if (cycles >= MAX_CYCLES)
		begin
			$display("timeout: run did not finish within %0d cycles", MAX_CYCLES);
			$display(">>> FAIL");
			$finish;
		end
	end

	initial
	begin
		int     e0;
		int     res_cycles;
		zaddr_t a;
		zaddr_t addrs [N_RW];
		logic   wr;
		rst = 1'b1;
		za = '0;
		zd_in = '0;
		mreq_n = 1'b1;
		iorq_n = 1'b1;
		rd_n = 1'b1;
		wr_n = 1'b1;
		m1_n = 1'b1;
		keys = '0;
		video_req = 1'b0;
		video_addr = '0;
		dram_rrdy = 1'b0;
		dram_rddata = '0;
		rrdy_d1 = 1'b0;
		rd_d1 = '0;
		video_on = 1'b0;
		seed = 20008;
		vseed = ~seed;
		errors = 0;
		checks = 0;
		cycles = 0;
		nvid = 0;
		m7ffd = '0;
		meff7 = '0;
		m_border = '0;
		m_beep = 1'b0;
		repeat (4) @(posedge fclk);
		rst <= 1'b0;
		res_cycles = 0;
		// count the cycles res stays up once rst is gone
		@(negedge fclk);
		while (res !== 1'b0)
		begin
			res_cycles++;
			@(negedge fclk);
		end

		e0 = errors;
		check(res_cycles, 1 << RST_CNT_SIZE, "reset stretch length");
		check(wait_n, 1'b1, "wait_n after reset");
		check(zd_oe, 1'b0, "zd_oe after reset");
		check(dram_req, 1'b0, "dram_req after reset");
		check(border, 3'd0, "border after reset");
		check(beep, 1'b0, "beep after reset");
		end_test("reset", e0);

		e0 = errors;
		for (int i = 0; i < N_FE; i++)
		begin
			port_write({8'(next_rand()), 8'hFE}, zdata_t'(next_rand()));
			@(negedge fclk);
			check(border, m_border, "border");
			check(beep, m_beep, "beep");
			fe_read(5'(next_rand()));
		end
		end_test("port fe", e0);

		e0 = errors;
		for (int i = 0; i < N_PAGE; i++)
		begin
			port_write(16'h7FFD, zdata_t'(next_rand()) & 8'hDF);
			for (int j = 0; j < N_RW; j++)
			begin
				addrs[j] = ram_addr();
				mem_access(addrs[j], 1'b1, zdata_t'(next_rand()), 1'b1);
			end
			for (int j = 0; j < N_RW; j++)
				mem_access(addrs[j], 1'b0, '0, 1'b1);
		end
		end_test("paging", e0);

		e0 = errors;
		port_write(16'h7FFD, 8'h00);
		mem_access(zaddr_t'(next_rand()) & 16'h3FFF, 1'b0, '0, 1'b1);
		mem_access(zaddr_t'(next_rand()) & 16'h3FFF, 1'b0, '0, 1'b1);
		port_write(16'h7FFD, 8'h10);
		mem_access(zaddr_t'(next_rand()) & 16'h3FFF, 1'b0, '0, 1'b1);
		mem_access(zaddr_t'(next_rand()) & 16'h3FFF, 1'b1, zdata_t'(next_rand()), 1'b0);
		port_write(16'hEFF7, 8'h08);
		a = zaddr_t'(next_rand()) & 16'h3FFF;
		mem_access(a, 1'b1, zdata_t'(next_rand()), 1'b1);
		mem_access(a, 1'b0, '0, 1'b1);
		port_write(16'hEFF7, 8'h00);
		end_test("rom and eff7", e0);

		e0 = errors;
		video_on <= 1'b1;
		for (int i = 0; i < N_CONT; i++)
		begin
			wr = next_rand() & 1;
			mem_access(ram_addr(), wr, zdata_t'(next_rand()), 1'b1);
		end
		video_on <= 1'b0;
		@(negedge fclk);
		while (vq.size() != 0)
			@(negedge fclk);
		if (nvid == 0)
		begin
			errors++;
			$display("no video fetch completed during the contention test");
		end
		end_test("contention", e0);

		// lock stays set until the next reset, so this runs last
		e0 = errors;
		port_write(16'h7FFD, zdata_t'(next_rand()) | 8'h20);
		for (int i = 0; i < 4; i++)
		begin
			if (i > 0)
				port_write(16'h7FFD, zdata_t'(next_rand()));
			a = zaddr_t'(next_rand()) | 16'hC000;
			mem_access(a, 1'b1, zdata_t'(next_rand()), 1'b1);
			mem_access(a, 1'b0, '0, 1'b1);
		end
		end_test("lock", e0);

		$display("tests 6, checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display(">>> PASS");
		else
			$display(">>> FAIL");
		$finish;
	end

endmodule

// ==== verilog/zx_top.sv ====
module zx_top
	import zx_bus_pkg::*, zx_mem_pkg::*;
#(
	parameter int RST_CNT_SIZE = 4,
	parameter int SLOT_LEN     = 4
)
(
	input  logic       fclk,
	input  logic       rst,
	input  zaddr_t     za,
	input  zdata_t     zd_in,
	input  logic       mreq_n,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	input  logic       m1_n,
	input  logic [4:0] keys,
	output zdata_t     zd_out,
	output logic       zd_oe,
	output logic       wait_n,
	output logic       res,
	output logic [2:0] border,
	output logic       beep,
	input  logic       video_req,
	input  dram_addr_t video_addr,
	output logic       video_strobe,
	output dram_data_t video_data,
	output logic       dram_req,
	output dram_cmd_t  dram_cmd,
	input  logic       dram_rrdy,
	input  dram_data_t dram_rddata
);

	logic       rst_int;
	zx_ports_t  ports;
	logic       cpu_req;
	dram_cmd_t  cpu_cmd;
	logic       cpu_strobe;
	dram_data_t rddata;
	zdata_t     port_dout;
	logic       port_oe;
	zdata_t     mem_dout;
	logic       mem_oe;

	resetter #(.RST_CNT_SIZE(RST_CNT_SIZE)) u_resetter (
		.fclk    (fclk),
		.rst     (rst),
		.rst_int (rst_int)
	);

	zports u_zports (
		.fclk   (fclk),
		.rst    (rst_int),
		.za     (za),
		.zd_in  (zd_in),
		.iorq_n (iorq_n),
		.rd_n   (rd_n),
		.wr_n   (wr_n),
		.m1_n   (m1_n),
		.keys   (keys),
		.ports  (ports),
		.zd_out (port_dout),
		.zd_oe  (port_oe)
	);

	zmem u_zmem (
		.fclk       (fclk),
		.rst        (rst_int),
		.za         (za),
		.zd_in      (zd_in),
		.mreq_n     (mreq_n),
		.rd_n       (rd_n),
		.wr_n       (wr_n),
		.ports      (ports),
		.cpu_req    (cpu_req),
		.cpu_cmd    (cpu_cmd),
		.cpu_strobe (cpu_strobe),
		.rddata     (rddata),
		.wait_n     (wait_n),
		.zd_out     (mem_dout),
		.zd_oe      (mem_oe)
	);

	arbiter #(.SLOT_LEN(SLOT_LEN)) u_arbiter (
		.fclk         (fclk),
		.rst          (rst_int),
		.cpu_req      (cpu_req),
		.cpu_cmd      (cpu_cmd),
		.cpu_strobe   (cpu_strobe),
		.video_req    (video_req),
		.video_addr   (video_addr),
		.video_strobe (video_strobe),
		.rddata       (rddata),
		.dram_req     (dram_req),
		.dram_cmd     (dram_cmd),
		.dram_rrdy    (dram_rrdy),
		.dram_rddata  (dram_rddata)
	);

	// each block zeroes its data when not driving
	assign zd_out     = port_dout | mem_dout;
	assign zd_oe      = port_oe | mem_oe;
	assign res        = rst_int;
	assign border     = ports.border;
	assign beep       = ports.beep;
	assign video_data = rddata;

endmodule

// ==== verilog/arbiter.sv ====
module arbiter
	import zx_mem_pkg::*;
#(
	parameter int SLOT_LEN = 4
)
(
	input  logic       fclk,
	input  logic       rst,
	input  logic       cpu_req,
	input  dram_cmd_t  cpu_cmd,
	output logic       cpu_strobe,
	input  logic       video_req,
	input  dram_addr_t video_addr,
	output logic       video_strobe,
	output dram_data_t rddata,
	output logic       dram_req,
	output dram_cmd_t  dram_cmd,
	input  logic       dram_rrdy,
	input  dram_data_t dram_rddata
);

	localparam int SLOT_W = $clog2(SLOT_LEN);

	typedef enum logic [1:0] {none, cpu, video} owner_t;

	logic [SLOT_W-1:0] slot_cnt;
	logic              slot_last;
	logic              video_pend;
	logic              cpu_busy;
	dram_addr_t        video_addr_r;
	owner_t            winner;
	owner_t            cur_owner;
	owner_t            own_d1;
	owner_t            own_d2;

	assign slot_last = (slot_cnt == SLOT_W'(SLOT_LEN - 1));

	// decided one cycle early so dram_req lands on the first slot cycle
	always_comb
	begin
		winner = none;
		if (slot_last)
		begin
			if (video_pend)
				winner = video;
			else if (cpu_req && !cpu_busy)
				winner = cpu;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			slot_cnt   <= '0;
			video_pend <= 1'b0;
			cpu_busy   <= 1'b0;
			cur_owner  <= none;
			own_d1     <= none;
			own_d2     <= none;
		end
		else
		begin
			slot_cnt <= slot_last ? '0 : slot_cnt + 1'b1;

			if (video_req)
				video_pend <= 1'b1;
			else if (winner == video)
				video_pend <= 1'b0;

			if (winner == cpu)
				cpu_busy <= 1'b1;
			else if (cpu_strobe)
				cpu_busy <= 1'b0;

			// owner of each request follows it to its return
			cur_owner <= winner;
			own_d1    <= cur_owner;
			own_d2    <= own_d1;
		end
	end

	always_ff @(posedge fclk)
	begin
		if (video_req)
			video_addr_r <= video_addr;
		if (winner == video)
		begin
			dram_cmd.addr   <= video_addr_r;
			dram_cmd.rnw    <= 1'b1;
			dram_cmd.bsel   <= 2'b11;
			dram_cmd.wrdata <= '0;
		end
		else if (winner == cpu)
			dram_cmd <= cpu_cmd;
	end

	assign dram_req     = (cur_owner != none);
	assign cpu_strobe   = dram_rrdy & (own_d2 == cpu);
	assign video_strobe = dram_rrdy & (own_d2 == video);
	assign rddata       = dram_rddata;

endmodule

// ==== verilog/zmem.sv ====
module zmem
	import zx_bus_pkg::*, zx_mem_pkg::*;
(
	input  logic       fclk,
	input  logic       rst,
	input  zaddr_t     za,
	input  zdata_t     zd_in,
	input  logic       mreq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	input  zx_ports_t  ports,
	output logic       cpu_req,
	output dram_cmd_t  cpu_cmd,
	input  logic       cpu_strobe,
	input  dram_data_t rddata,
	output logic       wait_n,
	output zdata_t     zd_out,
	output logic       zd_oe
);

	typedef enum logic [1:0] {idle, request, hold} state_t;

	state_t state;
	logic   mem_act;
	logic   mem_act_r;
	logic   mem_start;
	logic   is_rom;
	page_t  page;
	zdata_t rd_byte;

	assign mem_act   = ~mreq_n & (~rd_n | ~wr_n);
	assign mem_start = mem_act & ~mem_act_r;

	assign is_rom = (za[15:14] == 2'd0) && !ports.peff7[RAM0_BIT];

	// 16K window to DRAM page
	always_comb
	begin
		case (za[15:14])
		2'd0:    page = ports.peff7[RAM0_BIT] ? page_t'(0) : (ROM_PAGE | ports.p7ffd[4]);
		2'd1:    page = WIN1_PAGE;
		2'd2:    page = WIN2_PAGE;
		default: page = {2'b00, ports.p7ffd[7:5], ports.p7ffd[2:0]};
		endcase
	end

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			mem_act_r <= 1'b0;
			state     <= idle;
			cpu_req   <= 1'b0;
			wait_n    <= 1'b1;
		end
		else
		begin
			mem_act_r <= mem_act;
			case (state)
			idle:
				// writes into ROM are dropped here
				if (mem_start && (!is_rom || !rd_n))
				begin
					state   <= request;
					cpu_req <= 1'b1;
					wait_n  <= 1'b0;
				end
			request:
				if (cpu_strobe)
				begin
					state   <= hold;
					cpu_req <= 1'b0;
					wait_n  <= 1'b1;
				end
			hold:
				if (!mem_act)
					state <= idle;
			default:
				state <= idle;
			endcase
		end
	end

	always_ff @(posedge fclk)
	begin
		if (state == idle && mem_start)
		begin
			cpu_cmd.addr   <= {page, za[13:1]};
			cpu_cmd.rnw    <= ~rd_n;
			cpu_cmd.bsel   <= za[0] ? 2'b10 : 2'b01;
			cpu_cmd.wrdata <= {zd_in, zd_in};
		end
		if (state == request && cpu_strobe)
			rd_byte <= cpu_cmd.bsel[1] ? rddata[15:8] : rddata[7:0];
	end

	assign zd_oe  = (state == hold) & cpu_cmd.rnw & ~rd_n;
	assign zd_out = zd_oe ? rd_byte : '0;

endmodule

// ==== verilog/zports.sv ====
module zports
	import zx_bus_pkg::*;
(
	input  logic       fclk,
	input  logic       rst,
	input  zaddr_t     za,
	input  zdata_t     zd_in,
	input  logic       iorq_n,
	input  logic       rd_n,
	input  logic       wr_n,
	input  logic       m1_n,
	input  logic [4:0] keys,
	output zx_ports_t  ports,
	output zdata_t     zd_out,
	output logic       zd_oe
);

	logic io_act;
	logic io_act_r;
	logic io_start;
	logic fe_hit;
	logic fe_rd;

	// m1_n low with iorq_n low is an interrupt acknowledge, not I/O
	assign io_act   = ~iorq_n & (~rd_n | ~wr_n) & m1_n;
	assign io_start = io_act & ~io_act_r;

	// #FE is partially decoded
	assign fe_hit = ~za[0];

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			io_act_r <= 1'b0;
			ports    <= '0;
			fe_rd    <= 1'b0;
		end
		else
		begin
			io_act_r <= io_act;

			if (io_start && !wr_n)
			begin
				if (za == PORT_7FFD && !ports.p7ffd[LOCK_BIT])
					ports.p7ffd <= zd_in;
				if (za == PORT_EFF7)
					ports.peff7 <= zd_in;
				if (fe_hit)
				begin
					ports.border <= zd_in[2:0];
					ports.beep   <= zd_in[4];
				end
			end

			if (io_start && !rd_n && fe_hit)
				fe_rd <= 1'b1;
			else if (rd_n)
				fe_rd <= 1'b0;
		end
	end

	// drop the bus as soon as rd_n goes back up
	assign zd_oe  = fe_rd & ~rd_n;
	assign zd_out = zd_oe ? {3'b111, keys} : '0;

endmodule

// ==== verilog/resetter.sv ====
module resetter
#(
	parameter int RST_CNT_SIZE = 4
)
(
	input  logic fclk,
	input  logic rst,
	output logic rst_int
);

	logic [RST_CNT_SIZE-1:0] cnt;

	always_ff @(posedge fclk)
	begin
		if (rst)
		begin
			cnt     <= '1;
			rst_int <= 1'b1;
		end
		else if (cnt != '0)
			cnt <= cnt - 1'b1;
		else
			rst_int <= 1'b0;
	end

endmodule

// ==== verilog/zx_mem_pkg.sv ====
package zx_mem_pkg;

	typedef logic [7:0]  page_t;
	typedef logic [20:0] dram_addr_t;
	typedef logic [15:0] dram_data_t;

	// ROM lives in the top DRAM pages, 252 and 253
	localparam page_t ROM_PAGE = 8'd252;

	// fixed RAM pages of windows 1 and 2
	localparam page_t WIN1_PAGE = 8'd5;
	localparam page_t WIN2_PAGE = 8'd2;

	typedef struct packed {
		dram_addr_t addr;
		logic       rnw;
		logic [1:0] bsel;
		dram_data_t wrdata;
	} dram_cmd_t;

endpackage

// ==== verilog/zx_bus_pkg.sv ====
package zx_bus_pkg;

	typedef logic [15:0] zaddr_t;
	typedef logic [7:0]  zdata_t;

	// fully decoded port addresses
	localparam zaddr_t PORT_7FFD = 16'h7FFD;
	localparam zaddr_t PORT_EFF7 = 16'hEFF7;

	// p7ffd bit that locks further paging writes
	localparam int LOCK_BIT = 5;

	// peff7 bit 3 puts RAM page 0 into window 0
	localparam int RAM0_BIT = 3;

	typedef struct packed {
		zdata_t     p7ffd;
		zdata_t     peff7;
		logic [2:0] border;
		logic       beep;
	} zx_ports_t;

endpackage
